//--- Makefile
# Verilator build and run for the front-end testbench

OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f src.f \
		--top-module tb_afe -Mdir $(OBJ) -o sim

run: compile
	./$(OBJ)/sim > sim.log 2>&1; cat sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf $(OBJ) sim.log

//--- src.f
+incdir+verilog
verilog/afe_pkg.sv
verilog/cal_cfg_if.sv
verilog/linear_calib.sv
verilog/adc_channel.sv
verilog/dac_channel.sv
verilog/sys_regs.sv
verilog/edge_debounce.sv
verilog/afe_top.sv
tests/tb_clock.sv
tests/tb_afe.sv

//--- tests/tb_afe.sv
////////////////////////////////////////
// testbench for the front-end datapath
//   bus tasks and register checks
//   reference model, sample queues
//   debounce checks, timeout
////////////////////////////////////////

`include "afe_settings.svh"

module tb_afe import afe_pkg::*; ();

  localparam int MAX_CYC = 3000;

  logic adc_clk;
  logic top_rst;
  logic [15:0] adc_dat0;
  logic [15:0] adc_dat1;
  smp_t dac_smp0;
  smp_t dac_smp1;
  logic exp_in;
  logic [`BUS_AW-1:0] bus_addr;
  logic [`BUS_DW-1:0] bus_wdata;
  logic bus_wen;
  logic bus_ren;
  smp_t adc_smp0;
  smp_t adc_smp1;
  logic [`SMP_W-1:0] dac_dat0;
  logic [`SMP_W-1:0] dac_dat1;
  logic [`BUS_DW-1:0] bus_rdata;
  logic bus_ack;
  logic edge_p;
  logic edge_n;

  // model copy of the calibration and loopback settings
  int a_gain[2];
  int a_ofs[2];
  int d_gain[2];
  int d_ofs[2];
  bit loop_sel[2];

  int q_adc0[$];
  int q_adc1[$];
  int q_dac0[$];
  int q_dac1[$];

  bit rand_en;
  bit chk_en;
  string test_name;
  int mism_cnt;
  int other_cnt;
  int cyc_cnt;
  int p_cnt;
  int n_cnt;

  tb_clock tb_clock_inst (
    .adc_clk_o (adc_clk),
    .top_rst_o (top_rst)
  );

  afe_top afe_top_inst (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .adc_dat0_i  (adc_dat0),
    .adc_dat1_i  (adc_dat1),
    .dac_smp0_i  (dac_smp0),
    .dac_smp1_i  (dac_smp1),
    .exp_i       (exp_in),
    .bus_addr_i  (bus_addr),
    .bus_wdata_i (bus_wdata),
    .bus_wen_i   (bus_wen),
    .bus_ren_i   (bus_ren),
    .adc_smp0_o  (adc_smp0),
    .adc_smp1_o  (adc_smp1),
    .dac_dat0_o  (dac_dat0),
    .dac_dat1_o  (dac_dat1),
    .bus_rdata_o (bus_rdata),
    .bus_ack_o   (bus_ack),
    .edge_p_o    (edge_p),
    .edge_n_o    (edge_n)
  );

  ////////////////////////////////////////
  // reference rules
  ////////////////////////////////////////

  // scale, drop 13 fraction bits, add offset, clamp
  function automatic int calib_rule(input int x, input int gain, input int ofs);
    int s;
    s = ((x * gain) >>> 13) + ofs;
    if (s > 8191) begin
      s = 8191;
    end else if (s < -8192) begin
      s = -8192;
    end
    return s;
  endfunction

  // inverted offset pins to two's complement
  // code 0 is full scale positive, all ones full scale negative
  function automatic int pin_to_smp(input logic [15:0] p);
    return 8191 - int'(p[15:2]);
  endfunction

  // two's complement back to the inverted offset code
  function automatic int smp_to_pin(input int s);
    return 8191 - s;
  endfunction

  task automatic report_mismatch(input string what, input int exp, input int act);
    $display("MISMATCH %s %s: expected %0d, actual %0d", test_name, what, exp, act);
    mism_cnt++;
  endtask

  task automatic report_error(input string msg);
    $display("ERROR %s: %s", test_name, msg);
    other_cnt++;
  endtask

  ////////////////////////////////////////
  // bus tasks
  ////////////////////////////////////////

  // ack must be high the cycle after the strobe and low after that
  task automatic check_ack();
    @(posedge adc_clk);
    #10;
    bus_wen = 1'b0;
    bus_ren = 1'b0;
    assert (bus_ack === 1'b1) else report_error("no ack one cycle after strobe");
  endtask

  task automatic bus_write(input logic [4:0] addr, input logic [31:0] data);
    @(posedge adc_clk);
    #10;
    bus_addr  = addr;
    bus_wdata = data;
    bus_wen   = 1'b1;
    check_ack();
    @(posedge adc_clk);
    #10;
    assert (bus_ack === 1'b0) else report_error("ack held longer than one cycle");
  endtask

  task automatic bus_read(input logic [4:0] addr, output logic [31:0] data);
    @(posedge adc_clk);
    #10;
    bus_addr = addr;
    bus_ren  = 1'b1;
    check_ack();
    data = bus_rdata;
    @(posedge adc_clk);
    #10;
    assert (bus_ack === 1'b0) else report_error("ack held longer than one cycle");
  endtask

  task automatic read_expect(input logic [4:0] addr, input logic [31:0] exp);
    logic [31:0] rd;
    bus_read(addr, rd);
    assert (rd === exp) else report_mismatch($sformatf("reg 0x%02h", addr), exp, rd);
  endtask

  // calibration write and matching model update
  task automatic set_cal(input bit dac, input int ch, input int gain, input int ofs);
    logic [31:0] w;
    w = {gain[15:0], 2'b00, ofs[13:0]};
    bus_write(dac ? (ch ? `REG_DAC_CAL1 : `REG_DAC_CAL0)
                  : (ch ? `REG_ADC_CAL1 : `REG_ADC_CAL0), w);
    if (dac) begin
      d_gain[ch] = gain;
      d_ofs[ch]  = ofs;
    end else begin
      a_gain[ch] = gain;
      a_ofs[ch]  = ofs;
    end
  endtask

  task automatic set_loop(input bit l0, input bit l1);
    bus_write(`REG_CTL, {30'd0, l1, l0});
    loop_sel[0] = l0;
    loop_sel[1] = l1;
  endtask

  // checking runs only while settings are stable
  task automatic run_samples(input string name, input int n);
    test_name = name;
    repeat (2) @(posedge adc_clk);
    chk_en = 1'b1;
    repeat (n) @(posedge adc_clk);
    chk_en = 1'b0;
  endtask

  ////////////////////////////////////////
  // stimulus and checkers
  ////////////////////////////////////////

  always @(posedge adc_clk) begin
    #10;
    if (rand_en) begin
      adc_dat0 = 16'($urandom);
      adc_dat1 = 16'($urandom);
      dac_smp0 = smp_t'($urandom);
      dac_smp1 = smp_t'($urandom);
    end
  end

  // sampled on the falling edge where inputs and outputs are settled
  always @(negedge adc_clk) begin
    int d0;
    int d1;
    int e;
    if (!chk_en) begin
      q_adc0.delete();
      q_adc1.delete();
      q_dac0.delete();
      q_dac1.delete();
    end else begin
      d0 = calib_rule(int'(dac_smp0), d_gain[0], d_ofs[0]);
      d1 = calib_rule(int'(dac_smp1), d_gain[1], d_ofs[1]);
      q_dac0.push_back(smp_to_pin(d0));
      q_dac1.push_back(smp_to_pin(d1));
      q_adc0.push_back(calib_rule(loop_sel[0] ? d0 : pin_to_smp(adc_dat0),
                                  a_gain[0], a_ofs[0]));
      q_adc1.push_back(calib_rule(loop_sel[1] ? d1 : pin_to_smp(adc_dat1),
                                  a_gain[1], a_ofs[1]));
      // loopback adds one cycle through the DAC calibration
      if (q_adc0.size() > (loop_sel[0] ? 4 : 3)) begin
        e = q_adc0.pop_front();
        assert (int'(adc_smp0) == e) else report_mismatch("adc_smp0", e, int'(adc_smp0));
      end
      if (q_adc1.size() > (loop_sel[1] ? 4 : 3)) begin
        e = q_adc1.pop_front();
        assert (int'(adc_smp1) == e) else report_mismatch("adc_smp1", e, int'(adc_smp1));
      end
      if (q_dac0.size() > 3) begin
        e = q_dac0.pop_front();
        assert (int'(dac_dat0) == e) else report_mismatch("dac_dat0", e, int'(dac_dat0));
      end
      if (q_dac1.size() > 3) begin
        e = q_dac1.pop_front();
        assert (int'(dac_dat1) == e) else report_mismatch("dac_dat1", e, int'(dac_dat1));
      end
    end
  end

  // edge pulse counters
  always @(negedge adc_clk) begin
    if (!top_rst) begin
      if (edge_p) p_cnt++;
      if (edge_n) n_cnt++;
    end
  end

  // run limit
  always @(posedge adc_clk) begin
    cyc_cnt++;
    if (cyc_cnt >= MAX_CYC) begin
      $display("ERROR timeout after %0d cycles", cyc_cnt);
      $display("Simulation failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    int base;
    int first;
    void'($urandom(32'h93f1));
    adc_dat0 = '0;
    adc_dat1 = '0;
    dac_smp0 = '0;
    dac_smp1 = '0;
    exp_in = 1'b0;
    bus_addr = '0;
    bus_wdata = '0;
    bus_wen = 1'b0;
    bus_ren = 1'b0;
    rand_en = 1'b0;
    chk_en = 1'b0;
    mism_cnt = 0;
    other_cnt = 0;
    cyc_cnt = 0;
    p_cnt = 0;
    n_cnt = 0;
    test_name = "reset";
    for (int i = 0; i < 2; i++) begin
      a_gain[i] = 'h2000;
      d_gain[i] = 'h2000;
      a_ofs[i] = 0;
      d_ofs[i] = 0;
      loop_sel[i] = 1'b0;
    end
    @(negedge top_rst);
    @(negedge adc_clk);
    assert (bus_ack === 1'b0 && edge_p === 1'b0 && edge_n === 1'b0)
      else report_error("strobe outputs not low after reset");
    assert (adc_smp0 === '0 && adc_smp1 === '0) else report_error("ADC outputs not zero");
    assert (dac_dat0 === '0 && dac_dat1 === '0) else report_error("DAC outputs not zero");

    // register bank
    test_name = "regs";
    read_expect(`REG_ID, 32'h4146_4501);
    read_expect(`REG_CTL, 32'd0);
    read_expect(`REG_ADC_CAL0, 32'h2000_0000);
    read_expect(`REG_ADC_CAL1, 32'h2000_0000);
    read_expect(`REG_DAC_CAL0, 32'h2000_0000);
    read_expect(`REG_DAC_CAL1, 32'h2000_0000);
    read_expect(`REG_DEB_LEN, 32'd62500);
    bus_write(`REG_ADC_CAL1, 32'h1234_0567);
    read_expect(`REG_ADC_CAL1, 32'h1234_0567);
    bus_write(`REG_CTL, 32'h0000_0003);
    read_expect(`REG_CTL, 32'h0000_0003);
    bus_write(`REG_DEB_LEN, 32'h0000_0100);
    read_expect(`REG_DEB_LEN, 32'h0000_0100);
    read_expect(5'h1C, 32'd0);
    set_cal(1'b0, 1, 'h2000, 0);
    set_loop(1'b0, 1'b0);

    // unity paths
    rand_en = 1'b1;
    run_samples("unity", 200);

    // gains 3.0 and -2.0 drive the ADC outputs into saturation
    set_cal(1'b0, 0, 'h6000, 1000);
    set_cal(1'b0, 1, -16384, -500);
    set_cal(1'b1, 0, 'h1800, -300);
    set_cal(1'b1, 1, 'h5000, 2000);
    run_samples("calib", 200);

    // loopback one channel at a time
    set_loop(1'b1, 1'b0);
    run_samples("loop0", 150);
    set_loop(1'b0, 1'b1);
    run_samples("loop1", 150);
    set_loop(1'b0, 1'b0);
    rand_en = 1'b0;

    // debounce
    test_name = "debounce";
    bus_write(`REG_DEB_LEN, 32'd8);
    repeat (5) @(posedge adc_clk);
    #10;
    base = p_cnt + n_cnt;
    exp_in = 1'b1;
    repeat (3) @(posedge adc_clk);
    #10;
    exp_in = 1'b0;
    repeat (30) @(posedge adc_clk);
    assert (p_cnt + n_cnt == base) else report_error("edge pulse from a short glitch");
    #10;
    base = p_cnt;
    first = -1;
    exp_in = 1'b1;
    // counters move on the falling edge, read them on the rising edge
    for (int i = 1; i <= 20; i++) begin
      @(posedge adc_clk);
      if (first < 0 && p_cnt != base) first = i;
    end
    assert (p_cnt == base + 1) else report_error("rising edge pulse count not one");
    assert (first > 0 && first <= 12) else report_error("rising edge pulse missing or late");
    @(posedge adc_clk);
    #10;
    base = n_cnt;
    exp_in = 1'b0;
    repeat (20) @(posedge adc_clk);
    assert (n_cnt == base + 1) else report_error("falling edge pulse count not one");

    $display("errors: mismatches %0d, other %0d", mism_cnt, other_cnt);
    if (mism_cnt + other_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- tests/tb_clock.sv
////////////////////////////////////////
// testbench clock and reset
//   adc_clk period 100
//   top_rst held for 2 rising edges
////////////////////////////////////////

module tb_clock (
  output logic adc_clk_o,
  output logic top_rst_o
);

  initial begin
    adc_clk_o = 1'b0;
    forever #50 adc_clk_o = ~adc_clk_o;
  end

  // release just after the second edge
  initial begin
    top_rst_o = 1'b1;
    repeat (2) @(posedge adc_clk_o);
    #10;
    top_rst_o = 1'b0;
  end

endmodule

//--- verilog/adc_channel.sv
////////////////////////////////////////
// one ADC channel
//   pin capture and format conversion
//   loopback select, calibration
////////////////////////////////////////

`include "afe_settings.svh"

module adc_channel import afe_pkg::*; (
  input  logic        adc_clk,
  input  logic        top_rst,
  // ADC pins, bits 1..0 reserved
  input  logic [15:0] adc_dat_i,
  // calibrated DAC sample for loopback
  input  smp_t        loop_smp_i,
  output smp_t        smp_o,
  cal_cfg_if.chan     cfg
);

  smp_t adc_raw;
  smp_t cal_in;

  ////////////////////////////////////////
  // capture
  ////////////////////////////////////////

  // converter delivers inverted offset binary
  // keep msb, flip the rest to get two's complement
  // pin bits 1..0 are reserved and dropped here
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      adc_raw <= '0;
    end else begin
      adc_raw <= {adc_dat_i[15], ~adc_dat_i[14:2]};
    end
  end

  // digital loopback mux
  // DAC sample skips the capture register
  always_comb begin
    cal_in = cfg.loop ? loop_smp_i : adc_raw;
  end

  ////////////////////////////////////////
  // calibration
  ////////////////////////////////////////

  linear_calib linear_calib_inst (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .smp_i   (cal_in),
    .gain_i  (cfg.adc_gain),
    .ofs_i   (cfg.adc_ofs),
    .smp_o   (smp_o)
  );

endmodule

//--- verilog/afe_pkg.sv
////////////////////////////////////////
// front-end types
//   sample, gain and offset
//   calibration and control words
//   bus write word union
////////////////////////////////////////

package afe_pkg;

`include "afe_settings.svh"

  // signed sample as seen inside the datapath
  typedef logic signed [`SMP_W-1:0] smp_t;

  // gain, fixed point with CAL_SHIFT fraction bits
  typedef logic signed [`GAIN_W-1:0] gain_t;

  // offset added after scaling
  typedef logic signed [`SMP_W-1:0] ofs_t;

  // calibration register layout
  typedef struct packed {
    gain_t      gain;
    logic [1:0] rsv;
    ofs_t       ofs;
  } cal_word_t;

  // control register layout
  typedef struct packed {
    logic [29:0] rsv;
    logic        loop1;
    logic        loop0;
  } ctl_word_t;

  // bus write word, view picked by address
  typedef union packed {
    cal_word_t cal;
    ctl_word_t ctl;
  } cfg_word_u;

endpackage

//--- verilog/afe_settings.svh
////////////////////////////////////////
// widths, register map, reset values
// and identification word of the
// analog front-end datapath
////////////////////////////////////////

`ifndef AFE_SETTINGS_SVH
`define AFE_SETTINGS_SVH

// data path widths
`define SMP_W        14
`define GAIN_W       16
// gain fraction bits, 0x2000 is unity
`define CAL_SHIFT    13

// bus widths
`define BUS_AW       5
`define BUS_DW       32

// register map
`define REG_ID       5'h00
`define REG_CTL      5'h04
`define REG_ADC_CAL0 5'h08
`define REG_ADC_CAL1 5'h0C
`define REG_DAC_CAL0 5'h10
`define REG_DAC_CAL1 5'h14
`define REG_DEB_LEN  5'h18

// identification and reset values
`define ID_WORD      32'h4146_4501
`define GAIN_RST     16'h2000
`define DEB_W        20
// about 0.5 ms at 125 MHz
`define DEB_LEN_RST  20'd62500

`endif

//--- verilog/afe_top.sv
////////////////////////////////////////
// analog front-end top level
//   register bank, debounce
//   two ADC and two DAC channels
//   DAC to ADC loopback routing
////////////////////////////////////////

`include "afe_settings.svh"

module afe_top import afe_pkg::*; (
  input  logic               adc_clk,
  input  logic               top_rst,
  // ADC pins
  input  logic [15:0]        adc_dat0_i,
  input  logic [15:0]        adc_dat1_i,
  // DAC samples
  input  smp_t               dac_smp0_i,
  input  smp_t               dac_smp1_i,
  // expansion input
  input  logic               exp_i,
  // register bus
  input  logic [`BUS_AW-1:0] bus_addr_i,
  input  logic [`BUS_DW-1:0] bus_wdata_i,
  input  logic               bus_wen_i,
  input  logic               bus_ren_i,
  // calibrated ADC samples
  output smp_t               adc_smp0_o,
  output smp_t               adc_smp1_o,
  // DAC pins
  output logic [`SMP_W-1:0]  dac_dat0_o,
  output logic [`SMP_W-1:0]  dac_dat1_o,
  output logic [`BUS_DW-1:0] bus_rdata_o,
  output logic               bus_ack_o,
  // debounced edges
  output logic               edge_p_o,
  output logic               edge_n_o
);

  logic [`DEB_W-1:0] deb_len;
  // DAC calibrated samples, looped back to ADC
  smp_t              dac_cal0;
  smp_t              dac_cal1;

  cal_cfg_if cfg0_if ();
  cal_cfg_if cfg1_if ();

  ////////////////////////////////////////
  // registers and debounce
  ////////////////////////////////////////

  sys_regs sys_regs_inst (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .bus_addr_i  (bus_addr_i),
    .bus_wdata_i (bus_wdata_i),
    .bus_wen_i   (bus_wen_i),
    .bus_ren_i   (bus_ren_i),
    .bus_rdata_o (bus_rdata_o),
    .bus_ack_o   (bus_ack_o),
    .deb_len_o   (deb_len),
    .cfg0        (cfg0_if.regs),
    .cfg1        (cfg1_if.regs)
  );

  edge_debounce edge_debounce_inst (
    .adc_clk  (adc_clk),
    .top_rst  (top_rst),
    .d_i      (exp_i),
    .len_i    (deb_len),
    .edge_p_o (edge_p_o),
    .edge_n_o (edge_n_o)
  );

  ////////////////////////////////////////
  // channels
  ////////////////////////////////////////

  // channel 0
  dac_channel dac_channel0_inst (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .smp_i     (dac_smp0_i),
    .cal_smp_o (dac_cal0),
    .dac_dat_o (dac_dat0_o),
    .cfg       (cfg0_if.chan)
  );

  adc_channel adc_channel0_inst (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .adc_dat_i  (adc_dat0_i),
    .loop_smp_i (dac_cal0),
    .smp_o      (adc_smp0_o),
    .cfg        (cfg0_if.chan)
  );

  // channel 1
  dac_channel dac_channel1_inst (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .smp_i     (dac_smp1_i),
    .cal_smp_o (dac_cal1),
    .dac_dat_o (dac_dat1_o),
    .cfg       (cfg1_if.chan)
  );

  adc_channel adc_channel1_inst (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .adc_dat_i  (adc_dat1_i),
    .loop_smp_i (dac_cal1),
    .smp_o      (adc_smp1_o),
    .cfg        (cfg1_if.chan)
  );

endmodule

//--- verilog/cal_cfg_if.sv
////////////////////////////////////////
// per channel calibration and loopback
// settings, register side and channel
// side modports
////////////////////////////////////////

interface cal_cfg_if import afe_pkg::*; ();

  // ADC path calibration
  gain_t adc_gain;
  ofs_t  adc_ofs;
  // DAC path calibration
  gain_t dac_gain;
  ofs_t  dac_ofs;
  // digital loopback select
  logic  loop;

  // register bank owns all settings
  modport regs (
    output adc_gain, adc_ofs, dac_gain, dac_ofs, loop
  );

  // ADC and DAC channels only read
  modport chan (
    input adc_gain, adc_ofs, dac_gain, dac_ofs, loop
  );

endinterface

//--- verilog/dac_channel.sv
////////////////////////////////////////
// one DAC channel
//   calibration of the outgoing sample
//   conversion to DAC pin format
////////////////////////////////////////

`include "afe_settings.svh"

module dac_channel import afe_pkg::*; (
  input  logic             adc_clk,
  input  logic             top_rst,
  input  smp_t             smp_i,
  // calibrated sample, also feeds loopback
  output smp_t             cal_smp_o,
  // DAC pin word
  output logic [`SMP_W-1:0] dac_dat_o,
  cal_cfg_if.chan          cfg
);

  smp_t cal_smp;

  ////////////////////////////////////////
  // calibration
  ////////////////////////////////////////

  linear_calib linear_calib_inst (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .smp_i   (smp_i),
    .gain_i  (cfg.dac_gain),
    .ofs_i   (cfg.dac_ofs),
    .smp_o   (cal_smp)
  );

  // 2 cycles after smp_i
  assign cal_smp_o = cal_smp;

  ////////////////////////////////////////
  // output register
  ////////////////////////////////////////

  // two's complement back to inverted offset binary
  // sign stays, magnitude bits flipped
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      dac_dat_o <= '0;
    end else begin
      dac_dat_o <= {cal_smp[`SMP_W-1], ~cal_smp[`SMP_W-2:0]};
    end
  end

endmodule

//--- verilog/edge_debounce.sv
////////////////////////////////////////
// debounce of one input
//   two flop synchronizer
//   stability counter, edge pulses
////////////////////////////////////////

`include "afe_settings.svh"

module edge_debounce (
  input  logic              adc_clk,
  input  logic              top_rst,
  input  logic              d_i,
  // required stable cycles
  input  logic [`DEB_W-1:0] len_i,
  output logic              edge_p_o,
  output logic              edge_n_o
);

  // sync[1] is the synchronized input, sync[2] its previous value
  logic [2:0]        sync;
  logic [`DEB_W-1:0] cnt;
  // debounced level
  logic              lvl;
  logic              chg;
  logic              upd;

  assign chg = sync[2] ^ sync[1];
  // input settled and differs from debounced level
  assign upd = (cnt == '0) && !chg && (sync[1] != lvl);

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      sync <= '0;
      cnt  <= '0;
      lvl  <= 1'b0;
    end else begin
      sync <= {sync[1:0], d_i};
      // restart on every change, else run down to zero
      if (chg) begin
        cnt <= len_i;
      end else if (cnt != '0) begin
        cnt <= cnt - 1'b1;
      end
      if (upd) begin
        lvl <= sync[1];
      end
    end
  end

  // one cycle each, lvl follows on the next edge
  assign edge_p_o = upd &  sync[1];
  assign edge_n_o = upd & ~sync[1];

endmodule

//--- verilog/linear_calib.sv
////////////////////////////////////////
// linear calibration, two stages
//   stage 1: sample times gain
//   stage 2: shift, offset, saturate
////////////////////////////////////////

`include "afe_settings.svh"

module linear_calib import afe_pkg::*; (
  input  logic  adc_clk,
  input  logic  top_rst,
  input  smp_t  smp_i,
  input  gain_t gain_i,
  input  ofs_t  ofs_i,
  output smp_t  smp_o
);

  // full product width
  localparam int PRD_W = `SMP_W + `GAIN_W;
  // product after dropping fraction bits, plus one for the add
  localparam int SUM_W = PRD_W - `CAL_SHIFT + 1;

  // output limits
  localparam smp_t SMP_MAX = {1'b0, {(`SMP_W-1){1'b1}}};
  localparam smp_t SMP_MIN = {1'b1, {(`SMP_W-1){1'b0}}};

  logic signed [PRD_W-1:0] prd;
  logic signed [SUM_W-1:0] sum;

  ////////////////////////////////////////
  // stage 1
  ////////////////////////////////////////

  // full signed product, nothing lost yet
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      prd <= '0;
    end else begin
      prd <= smp_i * gain_i;
    end
  end

  ////////////////////////////////////////
  // stage 2
  ////////////////////////////////////////

  // arithmetic shift by slicing, then offset
  // both operands sign extend to SUM_W
  always_comb begin
    sum = $signed(prd[PRD_W-1:`CAL_SHIFT]) + ofs_i;
  end

  // clamp to sample range
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      smp_o <= '0;
    end else if (sum > $signed(SMP_MAX)) begin
      smp_o <= SMP_MAX;
    end else if (sum < $signed(SMP_MIN)) begin
      smp_o <= SMP_MIN;
    end else begin
      // in range, upper bits are pure sign
      smp_o <= sum[`SMP_W-1:0];
    end
  end

endmodule

//--- verilog/sys_regs.sv
////////////////////////////////////////
// register bank on a strobe bus
//   write decode and config registers
//   one cycle ack, registered read-back
////////////////////////////////////////

`include "afe_settings.svh"

module sys_regs import afe_pkg::*; (
  input  logic               adc_clk,
  input  logic               top_rst,
  // strobe bus
  input  logic [`BUS_AW-1:0] bus_addr_i,
  input  logic [`BUS_DW-1:0] bus_wdata_i,
  input  logic               bus_wen_i,
  input  logic               bus_ren_i,
  output logic [`BUS_DW-1:0] bus_rdata_o,
  output logic               bus_ack_o,
  // debounce length
  output logic [`DEB_W-1:0]  deb_len_o,
  // channel settings
  cal_cfg_if.regs            cfg0,
  cal_cfg_if.regs            cfg1
);

  // write word seen as calibration or control view
  cfg_word_u            wword;
  logic [`BUS_DW-1:0]   rd_mux;

  assign wword = bus_wdata_i;

  ////////////////////////////////////////
  // write side
  ////////////////////////////////////////

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      cfg0.loop     <= 1'b0;
      cfg1.loop     <= 1'b0;
      // unity gain, zero offset
      cfg0.adc_gain <= `GAIN_RST;
      cfg0.adc_ofs  <= '0;
      cfg1.adc_gain <= `GAIN_RST;
      cfg1.adc_ofs  <= '0;
      cfg0.dac_gain <= `GAIN_RST;
      cfg0.dac_ofs  <= '0;
      cfg1.dac_gain <= `GAIN_RST;
      cfg1.dac_ofs  <= '0;
      deb_len_o     <= `DEB_LEN_RST;
    end else if (bus_wen_i) begin
      case (bus_addr_i)
        // control view
        `REG_CTL: begin
          cfg0.loop <= wword.ctl.loop0;
          cfg1.loop <= wword.ctl.loop1;
        end
        // calibration view
        `REG_ADC_CAL0: begin
          cfg0.adc_gain <= wword.cal.gain;
          cfg0.adc_ofs  <= wword.cal.ofs;
        end
        `REG_ADC_CAL1: begin
          cfg1.adc_gain <= wword.cal.gain;
          cfg1.adc_ofs  <= wword.cal.ofs;
        end
        `REG_DAC_CAL0: begin
          cfg0.dac_gain <= wword.cal.gain;
          cfg0.dac_ofs  <= wword.cal.ofs;
        end
        `REG_DAC_CAL1: begin
          cfg1.dac_gain <= wword.cal.gain;
          cfg1.dac_ofs  <= wword.cal.ofs;
        end
        `REG_DEB_LEN: begin
          deb_len_o <= bus_wdata_i[`DEB_W-1:0];
        end
        // ID and unmapped addresses ignore writes
        default: begin
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // read side
  ////////////////////////////////////////

  // reserved fields read as zero
  always_comb begin
    case (bus_addr_i)
      `REG_ID:       rd_mux = `ID_WORD;
      `REG_CTL:      rd_mux = {30'd0, cfg1.loop, cfg0.loop};
      `REG_ADC_CAL0: rd_mux = {cfg0.adc_gain, 2'b00, cfg0.adc_ofs};
      `REG_ADC_CAL1: rd_mux = {cfg1.adc_gain, 2'b00, cfg1.adc_ofs};
      `REG_DAC_CAL0: rd_mux = {cfg0.dac_gain, 2'b00, cfg0.dac_ofs};
      `REG_DAC_CAL1: rd_mux = {cfg1.dac_gain, 2'b00, cfg1.dac_ofs};
      `REG_DEB_LEN:  rd_mux = {{(`BUS_DW-`DEB_W){1'b0}}, deb_len_o};
      default:       rd_mux = '0;
    endcase
  end

  // ack for any strobe, data valid with ack
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      bus_ack_o   <= 1'b0;
      bus_rdata_o <= '0;
    end else begin
      bus_ack_o   <= bus_wen_i | bus_ren_i;
      bus_rdata_o <= bus_ren_i ? rd_mux : '0;
    end
  end

endmodule
